// File: common/trace_cfg.svh
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Trace unit configuration defaults
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`ifndef TRACE_CFG_SVH
`define TRACE_CFG_SVH

// Number of trace channels merged onto the flit stream
`define TRACE_NUM_CHANNELS 3

// Width of one event record in bits, three flit words
`define TRACE_DATA_WIDTH 40

// Longest DI packet in flits, header flits included
`define TRACE_MAX_PKT_LEN 5

`endif

// File: common/trace_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Trace unit shared types
// Flit words, DI addresses, loss counters and DI event codes
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
package trace_pkg;

   // One flit on the debug interconnect, header or payload
   typedef logic [15:0] di_word_t;

   // DI module address, same format for SRC and DEST
   typedef logic [15:0] di_addr_t;

   // Number of events dropped while a slot was busy
   typedef logic [15:0] ovf_count_t;

   // Packetizer FSM, three header flits then payload
   typedef enum logic [2:0] {
      pkt_idle,
      pkt_hdr_dest,
      pkt_hdr_src,
      pkt_hdr_flags,
      pkt_payload
   } pkt_state_t;

   // TYPE field of the flags flit, bits 15:14
   localparam logic [1:0] di_type_event = 2'b10;

   // TYPE_SUB field of the flags flit, bits 13:10
   localparam logic [3:0] ev_sub_first = 4'd0;
   // Follow-on packet of a split event
   localparam logic [3:0] ev_sub_cont = 4'd1;
   // Lost event report, count in first payload word
   localparam logic [3:0] ev_sub_overflow = 4'd5;

endpackage

// File: common/di_channel_if.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// DI flit stream with valid, last and ready handshake
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns

interface di_channel_if;

   // Flit present, held until ready
   logic valid;
   // Final flit of a packet
   logic last;
   // Flit word
   trace_pkg::di_word_t data;
   // Sink accepts the flit this cycle
   logic ready;

   // Packet source side
   modport sender (output valid, output last, output data, input ready);

   // Packet sink side
   modport receiver (input valid, input last, input data, output ready);

endinterface

// File: common/event_channel_if.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Pending event handoff from capture slot to packetizer
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns
`include "trace_cfg.svh"

interface event_channel_if #(
   parameter int DATA_WIDTH = `TRACE_DATA_WIDTH
);

   // Slot holds an event, level
   logic available;
   // Slot holds a lost event report instead of a record
   logic overflow;
   // Event record, or the loss count in bits 15:0
   logic [DATA_WIDTH-1:0] data;
   // Pulse with the final flit of the final packet
   logic consumed;

   modport capture (output available, output overflow, output data, input consumed);

   modport packetizer (input available, input overflow, input data, output consumed);

endinterface

// File: verilog/event_capture.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Event capture, one pending slot per trace channel
// Counts events lost while busy and reports them afterwards
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns
`include "trace_cfg.svh"

module event_capture #(
   parameter int NUM_CHANNELS = `TRACE_NUM_CHANNELS,
   parameter int DATA_WIDTH = `TRACE_DATA_WIDTH
) (
   input  logic                               clk,
   input  logic                               reset,
   input  logic [NUM_CHANNELS-1:0]            event_valid,
   input  logic [NUM_CHANNELS*DATA_WIDTH-1:0] event_data,
   event_channel_if.capture                   ev [NUM_CHANNELS]
);

   for (genvar i = 0; i < NUM_CHANNELS; i++) begin : g_chan
      logic avail_q;
      logic ovf_q;
      logic [DATA_WIDTH-1:0] data_q;
      trace_pkg::ovf_count_t count_q;
      logic [DATA_WIDTH-1:0] new_data;

      // This channel's record out of the packed input
      assign new_data = event_data[i*DATA_WIDTH +: DATA_WIDTH];

      always_ff @(posedge clk) begin
         if (reset) begin
            avail_q <= 1'b0;
            ovf_q <= 1'b0;
            count_q <= '0;
         end else if (avail_q) begin
            // Slot frees once the packetizer is done
            if (ev[i].consumed) begin
               avail_q <= 1'b0;
            end
            // Busy slot, event lost, saturate at all ones
            if (event_valid[i] && count_q != '1) begin
               count_q <= count_q + 1'b1;
            end
         end else if (count_q != '0) begin
            // Loss report wins over a new event
            avail_q <= 1'b1;
            ovf_q <= 1'b1;
            // An event on this edge is lost as well
            count_q <= trace_pkg::ovf_count_t'(event_valid[i]);
         end else if (event_valid[i]) begin
            avail_q <= 1'b1;
            ovf_q <= 1'b0;
         end
      end

      // Slot contents, loaded only while free
      always_ff @(posedge clk) begin
         if (!avail_q) begin
            if (count_q != '0) begin
               data_q <= DATA_WIDTH'(count_q);
            end else if (event_valid[i]) begin
               data_q <= new_data;
            end
         end
      end

      assign ev[i].available = avail_q;
      assign ev[i].overflow = ovf_q;
      assign ev[i].data = data_q;

      // Packetizer may only finish an event that is pending
      a_consumed_needs_avail: assert property (
         @(posedge clk) disable iff (reset) ev[i].consumed |-> avail_q
      ) else $error("channel %0d consumed without a pending event", i);
   end

endmodule

// File: packetizer/event_packetizer_core.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// DI event packetizer FSM, header flits then payload words
// Splits long events into continued packets of MAX_PKT_LEN
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns
`include "trace_cfg.svh"

module event_packetizer_core #(
   parameter int MAX_PKT_LEN = `TRACE_MAX_PKT_LEN,
   parameter int MAX_DATA_WORDS = (`TRACE_DATA_WIDTH + 15) / 16,
   localparam int IDX_WIDTH = $clog2(MAX_DATA_WORDS + 1)
) (
   input  logic                  clk,
   input  logic                  reset,
   input  trace_pkg::di_addr_t   src,
   input  trace_pkg::di_addr_t   dest,
   input  logic                  available,
   input  logic                  overflow,
   output logic                  consumed,
   input  logic [IDX_WIDTH-1:0]  num_words,
   output logic [IDX_WIDTH-1:0]  word_idx,
   input  trace_pkg::di_word_t   word,
   di_channel_if.sender          out
);

   // Payload room left after DEST, SRC and flags
   localparam int PAYLOAD_MAX = MAX_PKT_LEN - 3;
   localparam int CNT_WIDTH = $clog2(PAYLOAD_MAX + 1);

   trace_pkg::pkt_state_t state_q;
   // Next event word to send
   logic [IDX_WIDTH-1:0] idx_q;
   // Payload words already in this packet
   logic [CNT_WIDTH-1:0] pay_cnt_q;
   // Set after the first packet of an event
   logic cont_q;
   logic xfer;
   logic last_word;
   logic pkt_full;
   logic [3:0] sub;

   assign xfer = out.valid & out.ready;

   // Loss report always carries exactly one word
   assign last_word = overflow | (idx_q == num_words - 1'b1);
   assign pkt_full = (pay_cnt_q == CNT_WIDTH'(PAYLOAD_MAX - 1));

   always_comb begin
      if (overflow) begin
         sub = trace_pkg::ev_sub_overflow;
      end else if (cont_q) begin
         sub = trace_pkg::ev_sub_cont;
      end else begin
         sub = trace_pkg::ev_sub_first;
      end
   end

   // Word request goes straight to the slicer
   assign word_idx = idx_q;

   // Flit mux, valid in every state but idle
   always_comb begin
      out.valid = 1'b1;
      out.last = 1'b0;
      out.data = '0;
      case (state_q)
         trace_pkg::pkt_hdr_dest: out.data = dest;
         trace_pkg::pkt_hdr_src: out.data = src;
         trace_pkg::pkt_hdr_flags: out.data = {trace_pkg::di_type_event, sub, 10'h000};
         trace_pkg::pkt_payload: begin
            out.data = word;
            out.last = last_word | pkt_full;
         end
         default: out.valid = 1'b0;
      endcase
   end

   // Event done with the final word of the final packet
   assign consumed = xfer & (state_q == trace_pkg::pkt_payload) & last_word;

   always_ff @(posedge clk) begin
      if (reset) begin
         state_q <= trace_pkg::pkt_idle;
         idx_q <= '0;
         pay_cnt_q <= '0;
         cont_q <= 1'b0;
      end else begin
         case (state_q)
            trace_pkg::pkt_idle: begin
               if (available) begin
                  state_q <= trace_pkg::pkt_hdr_dest;
                  idx_q <= '0;
                  cont_q <= 1'b0;
               end
            end
            trace_pkg::pkt_hdr_dest: begin
               if (xfer) state_q <= trace_pkg::pkt_hdr_src;
            end
            trace_pkg::pkt_hdr_src: begin
               if (xfer) state_q <= trace_pkg::pkt_hdr_flags;
            end
            trace_pkg::pkt_hdr_flags: begin
               if (xfer) begin
                  state_q <= trace_pkg::pkt_payload;
                  pay_cnt_q <= '0;
               end
            end
            trace_pkg::pkt_payload: begin
               if (xfer) begin
                  idx_q <= idx_q + 1'b1;
                  pay_cnt_q <= pay_cnt_q + 1'b1;
                  if (last_word) begin
                     state_q <= trace_pkg::pkt_idle;
                  end else if (pkt_full) begin
                     // Words remain, open a continued packet at once
                     state_q <= trace_pkg::pkt_hdr_dest;
                     cont_q <= 1'b1;
                  end
               end
            end
            default: state_q <= trace_pkg::pkt_idle;
         endcase
      end
   end

   // Stalled flit must not change under back-pressure
   a_hold_on_stall: assert property (
      @(posedge clk) disable iff (reset)
      out.valid && !out.ready |=> out.valid && $stable(out.data) && $stable(out.last)
   ) else $error("flit changed while stalled");

endmodule

// File: packetizer/event_packetizer_fixedwidth.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Fixed-width event packetizer for one trace channel
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns
`include "trace_cfg.svh"

module event_packetizer_fixedwidth #(
   parameter int CHANNEL = 0,
   parameter int DATA_WIDTH = `TRACE_DATA_WIDTH,
   parameter int MAX_PKT_LEN = `TRACE_MAX_PKT_LEN,
   localparam int NUM_WORDS = (DATA_WIDTH + 15) / 16,
   localparam int IDX_WIDTH = $clog2(NUM_WORDS + 1),
   localparam int PAD_WIDTH = NUM_WORDS * 16
) (
   input  logic                 clk,
   input  logic                 reset,
   input  trace_pkg::di_addr_t  id,
   input  trace_pkg::di_addr_t  dest,
   event_channel_if.packetizer  ev,
   di_channel_if.sender         out
);

   trace_pkg::di_addr_t src;
   logic [IDX_WIDTH-1:0] word_idx;
   trace_pkg::di_word_t word;
   logic [PAD_WIDTH-1:0] padded;

   // Each channel sits one address above the previous
   assign src = id + trace_pkg::di_addr_t'(CHANNEL);

   // Zero fill above the record so the top word pads itself
   assign padded = PAD_WIDTH'(ev.data);

   always_comb begin
      if (ev.overflow) begin
         // Loss count lives in the low word
         word = ev.data[15:0];
      end else if (word_idx < IDX_WIDTH'(NUM_WORDS)) begin
         word = padded[16*word_idx +: 16];
      end else begin
         word = '0;
      end
   end

   event_packetizer_core #(
      .MAX_PKT_LEN(MAX_PKT_LEN),
      .MAX_DATA_WORDS(NUM_WORDS)
   ) u_core (
      .clk(clk),
      .reset(reset),
      .src(src),
      .dest(dest),
      .available(ev.available),
      .overflow(ev.overflow),
      .consumed(ev.consumed),
      .num_words(IDX_WIDTH'(NUM_WORDS)),
      .word_idx(word_idx),
      .word(word),
      .out(out)
   );

endmodule

// File: verilog/di_flit_arbiter.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Round-robin DI flit merge, grant held for a whole packet
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns
`include "trace_cfg.svh"

module di_flit_arbiter #(
   parameter int NUM_CHANNELS = `TRACE_NUM_CHANNELS,
   localparam int IDX_WIDTH = (NUM_CHANNELS > 1) ? $clog2(NUM_CHANNELS) : 1
) (
   input  logic           clk,
   input  logic           reset,
   di_channel_if.receiver in [NUM_CHANNELS],
   di_channel_if.sender   out
);

   logic [NUM_CHANNELS-1:0] req;
   logic [NUM_CHANNELS-1:0] last_flag;
   trace_pkg::di_word_t     data_arr [NUM_CHANNELS];
   // One-hot grant, channel 0 out of reset
   logic [NUM_CHANNELS-1:0] grant_q;
   logic [NUM_CHANNELS-1:0] grant_next;
   logic [IDX_WIDTH-1:0]    cur_idx;
   logic                    advance;

   for (genvar i = 0; i < NUM_CHANNELS; i++) begin : g_in
      assign req[i] = in[i].valid;
      assign last_flag[i] = in[i].last;
      assign data_arr[i] = in[i].data;
      // Only the granted sender sees ready
      assign in[i].ready = grant_q[i] & out.ready;
   end

   always_comb begin
      cur_idx = '0;
      for (int i = 0; i < NUM_CHANNELS; i++) begin
         if (grant_q[i]) cur_idx = IDX_WIDTH'(i);
      end
   end

   // Zero latency path from the granted channel
   assign out.valid = req[cur_idx];
   assign out.last = last_flag[cur_idx];
   assign out.data = data_arr[cur_idx];

   // Nearest requester after the current one, current channel last
   always_comb begin
      int cand;
      grant_next = grant_q;
      for (int off = NUM_CHANNELS; off >= 1; off--) begin
         cand = (int'(cur_idx) + off) % NUM_CHANNELS;
         if (req[cand]) grant_next = NUM_CHANNELS'(1) << cand;
      end
   end

   // Move after a last flit, or when the granted channel sits idle
   assign advance = ~out.valid | (out.ready & out.last);

   always_ff @(posedge clk) begin
      if (reset) begin
         grant_q <= NUM_CHANNELS'(1);
      end else if (advance) begin
         grant_q <= grant_next;
      end
   end

   a_grant_onehot: assert property (
      @(posedge clk) disable iff (reset) $onehot(grant_q)
   ) else $error("grant not one-hot %h", grant_q);

endmodule

// File: verilog/trace_debug_unit.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Debug trace unit top, event channels merged to DI flits
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns
`include "trace_cfg.svh"

module trace_debug_unit (
   input  logic                                           clk,
   input  logic                                           reset,
   input  trace_pkg::di_addr_t                            id,
   input  trace_pkg::di_addr_t                            dest,
   input  logic [`TRACE_NUM_CHANNELS-1:0]                 event_valid,
   input  logic [`TRACE_NUM_CHANNELS*`TRACE_DATA_WIDTH-1:0] event_data,
   input  logic                                           debug_out_ready,
   output logic                                           debug_out_valid,
   output logic                                           debug_out_last,
   output trace_pkg::di_word_t                            debug_out_data
);

   event_channel_if #(.DATA_WIDTH(`TRACE_DATA_WIDTH)) ev_if [`TRACE_NUM_CHANNELS] ();
   di_channel_if ch_if [`TRACE_NUM_CHANNELS] ();
   di_channel_if out_if ();

   event_capture #(
      .NUM_CHANNELS(`TRACE_NUM_CHANNELS),
      .DATA_WIDTH(`TRACE_DATA_WIDTH)
   ) u_capture (
      .clk(clk),
      .reset(reset),
      .event_valid(event_valid),
      .event_data(event_data),
      .ev(ev_if)
   );

   // One packetizer per channel, each with its own source address
   for (genvar i = 0; i < `TRACE_NUM_CHANNELS; i++) begin : g_pkt
      event_packetizer_fixedwidth #(
         .CHANNEL(i),
         .DATA_WIDTH(`TRACE_DATA_WIDTH),
         .MAX_PKT_LEN(`TRACE_MAX_PKT_LEN)
      ) u_packetizer (
         .clk(clk),
         .reset(reset),
         .id(id),
         .dest(dest),
         .ev(ev_if[i]),
         .out(ch_if[i])
      );
   end

   di_flit_arbiter #(
      .NUM_CHANNELS(`TRACE_NUM_CHANNELS)
   ) u_arbiter (
      .clk(clk),
      .reset(reset),
      .in(ch_if),
      .out(out_if)
   );

   // Merged stream onto the plain top-level ports
   assign debug_out_valid = out_if.valid;
   assign debug_out_last = out_if.last;
   assign debug_out_data = out_if.data;
   assign out_if.ready = debug_out_ready;

endmodule

// File: bench/trace_clock_gen.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Testbench clock, 40 ns period, reset held for 8 cycles
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns

module trace_clock_gen (
   output logic clk,
   output logic reset
);

   initial begin
      clk = 1'b0;
      forever #20 clk = ~clk;
   end

   // Release on a falling edge, away from the sampling edge
   initial begin
      reset = 1'b1;
      repeat (8) @(posedge clk);
      @(negedge clk);
      reset = 1'b0;
   end

endmodule

// File: bench/trace_debug_unit_tb.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Trace unit testbench, expected DI packets per channel
// checked flit by flit against the merged output stream
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns
`include "trace_cfg.svh"

module trace_debug_unit_tb;

   localparam int NCH = `TRACE_NUM_CHANNELS;
   localparam int DW = `TRACE_DATA_WIDTH;
   localparam int NW = (DW + 15) / 16;
   // Payload words per packet after the three header flits
   localparam int PAY = `TRACE_MAX_PKT_LEN - 3;

   logic clk;
   logic reset;
   trace_pkg::di_addr_t id;
   trace_pkg::di_addr_t dest;
   logic [NCH-1:0] event_valid;
   logic [NCH*DW-1:0] event_data;
   logic debug_out_ready;
   logic debug_out_valid;
   logic debug_out_last;
   trace_pkg::di_word_t debug_out_data;

   integer seed;
   // Expected flits per channel, {last, data}
   logic [16:0] exp_q [NCH][$];
   int pend [NCH];
   int pending = 0;
   // Model of each capture slot and its loss counter
   logic [15:0] lost [NCH];
   logic [NCH-1:0] busy;
   int hdr_pos;
   int cur_ch;
   trace_pkg::di_word_t exp_data;
   logic exp_last;
   logic rr_on;
   logic rand_ready;
   int rr_prev;
   logic xfer;
   logic src_ok;
   logic rr_ok;
   logic [15:0] src_ch;
   int value_errors = 0;
   int other_errors = 0;

   trace_clock_gen clock_gen_i (
      .clk(clk),
      .reset(reset)
   );

   trace_debug_unit trace_debug_unit_i (
      .clk(clk),
      .reset(reset),
      .id(id),
      .dest(dest),
      .event_valid(event_valid),
      .event_data(event_data),
      .debug_out_ready(debug_out_ready),
      .debug_out_valid(debug_out_valid),
      .debug_out_last(debug_out_last),
      .debug_out_data(debug_out_data)
   );

   assign xfer = debug_out_valid && debug_out_ready;
   // Channel index is the source address minus the base id
   assign src_ch = debug_out_data - id;

   always_comb begin
      src_ok = 1'b0;
      for (int c = 0; c < NCH; c++) begin
         if (src_ch == 16'(c) && pend[c] > 0) src_ok = 1'b1;
      end
      rr_ok = (rr_prev < 0) || (src_ch == 16'((rr_prev + 1) % NCH));
   end

   // Queue the DI packets for one event record or one loss report
   function automatic void expect_event(input int ch, input logic [DW-1:0] rec,
                                        input bit ovf);
      logic [NW*16-1:0] padded;
      logic [3:0] sub;
      int n;
      int sent;
      padded = '0;
      padded[DW-1:0] = rec;
      n = ovf ? 1 : NW;
      sent = 0;
      while (sent < n) begin
         // TYPE_SUB 5 for loss, 0 for the first packet, 1 after that
         sub = ovf ? 4'd5 : ((sent == 0) ? 4'd0 : 4'd1);
         exp_q[ch].push_back({1'b0, dest});
         exp_q[ch].push_back({1'b0, id + 16'(ch)});
         // TYPE EVENT is 2'b10
         exp_q[ch].push_back({1'b0, 2'b10, sub, 10'h000});
         pend[ch] += 3;
         pending += 3;
         for (int k = 0; k < PAY && sent < n; k++) begin
            exp_q[ch].push_back({(k == PAY - 1) || (sent == n - 1), padded[16*sent +: 16]});
            pend[ch]++;
            pending++;
            sent++;
         end
      end
   endfunction

   // Monitor and slot model, both on the rising edge
   always @(posedge clk) begin
      logic [NCH-1:0] done;
      done = '0;
      if (reset) begin
         for (int c = 0; c < NCH; c++) begin
            exp_q[c].delete();
            pend[c] = 0;
            lost[c] = '0;
         end
         busy = '0;
         pending = 0;
         hdr_pos = 0;
         cur_ch = -1;
         exp_data = '0;
         exp_last = 1'b0;
         rr_prev = -1;
      end else begin
         if (xfer) begin
            if (hdr_pos == 0) begin
               hdr_pos = 1;
            end else if (hdr_pos == 1) begin
               // Source flit names the channel, drop its dest and src entries
               cur_ch = src_ok ? int'(src_ch) : -1;
               if (cur_ch >= 0) begin
                  void'(exp_q[cur_ch].pop_front());
                  void'(exp_q[cur_ch].pop_front());
                  pend[cur_ch] -= 2;
                  pending -= 2;
                  {exp_last, exp_data} = exp_q[cur_ch][0];
               end
               rr_prev = rr_on ? cur_ch : -1;
               hdr_pos = 2;
            end else begin
               if (cur_ch >= 0 && pend[cur_ch] > 0) begin
                  void'(exp_q[cur_ch].pop_front());
                  pend[cur_ch]--;
                  pending--;
                  // Empty queue means the final flit of the slot content
                  done[cur_ch] = (pend[cur_ch] == 0);
                  if (pend[cur_ch] > 0) {exp_last, exp_data} = exp_q[cur_ch][0];
               end
               if (debug_out_last) begin
                  hdr_pos = 0;
                  exp_last = 1'b0;
               end else begin
                  hdr_pos++;
               end
            end
         end
         if (!rr_on) rr_prev = -1;
         for (int c = 0; c < NCH; c++) begin
            if (busy[c]) begin
               // Strobe into a busy slot is lost, even on the freeing edge
               if (event_valid[c] && lost[c] != 16'hffff) lost[c]++;
               if (done[c]) busy[c] = 1'b0;
            end else if (lost[c] != '0) begin
               expect_event(c, DW'(lost[c]), 1'b1);
               lost[c] = 16'(event_valid[c]);
               busy[c] = 1'b1;
            end else if (event_valid[c]) begin
               expect_event(c, event_data[c*DW +: DW], 1'b0);
               busy[c] = 1'b1;
            end
         end
      end
   end

   // Nothing expected means nothing on the stream, reset included
   a_idle: assert property (@(posedge clk) pending == 0 |-> !debug_out_valid)
      else begin
         value_errors++;
         $display("[ERROR] debug_out_valid %h expected 0", $sampled(debug_out_valid));
      end

   a_dest: assert property (@(posedge clk) disable iff (reset)
      xfer && hdr_pos == 0 |-> debug_out_data == dest)
      else begin
         value_errors++;
         $display("[ERROR] debug_out_data %h expected dest %h",
                  $sampled(debug_out_data), $sampled(dest));
      end

   a_src: assert property (@(posedge clk) disable iff (reset)
      xfer && hdr_pos == 1 |-> src_ok)
      else begin
         value_errors++;
         $display("[ERROR] debug_out_data %h not a source with packets pending",
                  $sampled(debug_out_data));
      end

   a_round_robin: assert property (@(posedge clk) disable iff (reset)
      xfer && hdr_pos == 1 && rr_on |-> rr_ok)
      else begin
         value_errors++;
         $display("[ERROR] debug_out_data %h source out of round-robin order, previous %h",
                  $sampled(debug_out_data), $sampled(rr_prev));
      end

   a_body: assert property (@(posedge clk) disable iff (reset)
      xfer && hdr_pos >= 2 |-> debug_out_data == exp_data)
      else begin
         value_errors++;
         $display("[ERROR] debug_out_data %h expected %h",
                  $sampled(debug_out_data), $sampled(exp_data));
      end

   a_last: assert property (@(posedge clk) disable iff (reset)
      xfer |-> debug_out_last == exp_last)
      else begin
         value_errors++;
         $display("[ERROR] debug_out_last %h expected %h",
                  $sampled(debug_out_last), $sampled(exp_last));
      end

   a_stall: assert property (@(posedge clk) disable iff (reset)
      debug_out_valid && !debug_out_ready |=>
      debug_out_valid && $stable(debug_out_data) && $stable(debug_out_last))
      else begin
         value_errors++;
         $display("[ERROR] debug_out_data %h debug_out_last %h changed while stalled",
                  $sampled(debug_out_data), $sampled(debug_out_last));
      end

   function automatic bit model_idle();
      bit idle;
      idle = (pending == 0) && (busy == '0);
      for (int c = 0; c < NCH; c++) begin
         if (lost[c] != '0) idle = 1'b0;
      end
      return idle;
   endfunction

   task automatic wait_reset_release();
      int cycles;
      cycles = 0;
      // Reset level is only settled from the first falling edge on
      @(negedge clk);
      while (reset && cycles < 20) begin
         @(negedge clk);
         cycles++;
      end
      if (reset) begin
         other_errors++;
         $display("Timeout: reset was never released");
      end
   endtask

   // Strobe the masked channels on count consecutive cycles
   task automatic strobe(input logic [NCH-1:0] mask, input int count);
      for (int n = 0; n < count; n++) begin
         @(negedge clk);
         for (int c = 0; c < NCH; c++) begin
            event_data[c*DW +: DW] = DW'({$random(seed), $random(seed)});
         end
         event_valid = mask;
      end
      @(negedge clk);
      event_valid = '0;
   endtask

   task automatic wait_drained(input string what);
      int cycles;
      cycles = 0;
      while (!model_idle() && cycles < 1000) begin
         @(negedge clk);
         // About one stall cycle in four
         if (rand_ready) debug_out_ready = ($random(seed) % 4) != 0;
         cycles++;
      end
      if (!model_idle()) begin
         other_errors++;
         $display("Timeout: expected packets for %s never all arrived", what);
      end
      debug_out_ready = 1'b1;
   endtask

   initial begin
      seed = 32'h185e4166;
      id = 16'h0040;
      dest = 16'h0001;
      event_valid = '0;
      event_data = '0;
      debug_out_ready = 1'b1;
      rand_ready = 1'b0;
      rr_on = 1'b0;
      wait_reset_release();
      // One event per channel, split into two packets each
      for (int c = 0; c < NCH; c++) begin
         strobe(NCH'(1) << c, 1);
         wait_drained("single event");
      end
      // Back to back strobes into a busy slot give a loss report
      strobe(NCH'(2), 3);
      wait_drained("overflow burst");
      // All channels at once, whole packets in rotation
      rr_on = 1'b1;
      strobe('1, 1);
      wait_drained("simultaneous events");
      rr_on = 1'b0;
      // Random stalls on the flit stream
      rand_ready = 1'b1;
      for (int r = 0; r < 8; r++) begin
         strobe(NCH'($random(seed)) | NCH'(1), 1 + r % 2);
         wait_drained("back-pressure round");
      end
      rand_ready = 1'b0;
      repeat (4) @(negedge clk);
      $display("Errors: %0d value, %0d other", value_errors, other_errors);
      if (value_errors == 0 && other_errors == 0) begin
         $display("Result: PASSED");
      end else begin
         $display("Result: FAILED");
      end
      $finish;
   end

endmodule

// File: all.f
+incdir+common
common/trace_pkg.sv
common/di_channel_if.sv
common/event_channel_if.sv
verilog/event_capture.sv
packetizer/event_packetizer_core.sv
packetizer/event_packetizer_fixedwidth.sv
verilog/di_flit_arbiter.sv
verilog/trace_debug_unit.sv
bench/trace_clock_gen.sv
bench/trace_debug_unit_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the trace unit testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --assert -f all.f --top-module trace_debug_unit_tb &&
./obj_dir/Vtrace_debug_unit_tb > sim.log 2>&1 ||
{ cat sim.log 2>/dev/null; echo "Build or simulation error"; exit 1; }

cat sim.log
grep -q "Result: FAILED" sim.log && { echo "Simulation reported failure"; exit 1; }
grep -q "Result: PASSED" sim.log || { echo "No result line in log"; exit 1; }
echo "Simulation finished without failure"
